// File: Makefile
TOOL   := verilator
FLAGS  := --binary --timing -j 0
TOP    := htable_tb
FLIST  := src.f
OBJDIR := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR)

// File: dv/htable_tb.sv
module htable_tb;
    import htable_pkg::*;

    localparam int SEED        = 89691;
    localparam int LATENCY     = 3;    // Counted edges from drive point to sample point
    localparam int INIT_LIMIT  = 200;
    localparam int DRAIN_LIMIT = 20;

    logic         clk;
    logic         arst_n;
    logic         req_valid;
    htable_req_t  req;
    logic         init_done;
    logic         resp_valid;
    htable_resp_t resp;

    int           cyc;
    value_t       model [key_t];
    int           bucket_cnt [NUM_BUCKETS];
    htable_resp_t exp_q [$];
    int           due_q [$];
    key_t         pool [$];

    htable_top uut (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req        (req),
        .init_done  (init_done),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    initial cyc = 0;
    always @(posedge clk) cyc <= cyc + 1;

    // ======================================================================
    // Failure reporting and compares
    // ======================================================================
    task automatic fail_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_resp(input htable_resp_t got, input htable_resp_t want);
        if (got !== want) begin
            $display("mismatch at %0t: resp got %h expected %h", $time, got, want);
            fail_run();
        end
    endtask

    task automatic check_arrival(input int got, input int want);
        if (got != want) begin
            $display("mismatch at %0t: resp_valid cycle got %0d expected %0d",
                     $time, got, want);
            fail_run();
        end
    endtask

    // ======================================================================
    // Reference model
    // ======================================================================
    // Bit i of the key lands on index bit i mod 6
    function automatic hash_t model_hash(input key_t key);
        hash_t h;
        h = '0;
        for (int i = 0; i < KEY_WID; i++) begin
            h[i % HASH_WID] = h[i % HASH_WID] ^ key[i];
        end
        return h;
    endfunction

    function automatic htable_resp_t predict(input htable_op_e op, input key_t key,
                                             input value_t value);
        htable_resp_t r;
        hash_t        h;
        h       = model_hash(key);
        r       = '0;
        r.op    = op;
        r.key   = key;
        r.found = (model.exists(key) != 0);
        if (r.found) begin
            r.value = model[key];
        end
        case (op)
            OP_INSERT: begin
                if (r.found) begin
                    model[key] = value;
                end else if (bucket_cnt[h] >= NUM_WAYS) begin
                    r.full = 1'b1;
                end else begin
                    model[key] = value;
                    bucket_cnt[h]++;
                end
            end
            OP_DELETE: begin
                if (r.found) begin
                    model.delete(key);
                    bucket_cnt[h]--;
                end
            end
            default: ;
        endcase
        return r;
    endfunction

    // ======================================================================
    // Stimulus helpers
    // ======================================================================
    task automatic issue(input htable_op_e op, input key_t key, input value_t value);
        htable_req_t r;
        r.op    = op;
        r.key   = key;
        r.value = value;
        exp_q.push_back(predict(op, key, value));
        due_q.push_back(cyc + LATENCY);
        req       = r;
        req_valid = 1'b1;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Inserts weighted up so buckets fill
    function automatic htable_op_e rand_op();
        int unsigned r;
        r = $urandom_range(3, 0);
        if (r == 0) return OP_LOOKUP;
        if (r == 3) return OP_DELETE;
        return OP_INSERT;
    endfunction

    function automatic key_t pick_key(input int lo, input int hi);
        return pool[$urandom_range(hi, lo)];
    endfunction

    task automatic wait_init();
        int n;
        n = 0;
        while (!init_done && n < INIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!init_done) begin
            $display("timeout: init_done never rose after reset");
            fail_run();
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: responses still outstanding at end of run");
            fail_run();
        end
    endtask

    // Responses are sampled mid-cycle
    always @(negedge clk) begin
        htable_resp_t want;
        int           due;
        if (resp_valid) begin
            if (exp_q.size() == 0) begin
                $display("response arrived with no request outstanding");
                fail_run();
            end else begin
                want = exp_q.pop_front();
                due  = due_q.pop_front();
                check_arrival(cyc, due);
                check_resp(resp, want);
            end
        end else if (due_q.size() != 0 && cyc >= due_q[0]) begin
            $display("timeout: expected response did not arrive");
            fail_run();
        end
    end

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin : main
        key_t k;
        void'($urandom(SEED));
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        wait_init();

        // Empty table after the sweep
        repeat (8) issue(OP_LOOKUP, key_t'($urandom), '0);
        repeat (8) pool.push_back(key_t'($urandom));

        // Insert, lookup, replace
        k = pool[0];
        issue(OP_INSERT, k, value_t'($urandom));
        issue(OP_LOOKUP, k, '0);
        idle(3);
        issue(OP_INSERT, k, value_t'($urandom));
        issue(OP_LOOKUP, k, '0);
        idle(3);

        // Delete, miss, delete of absent key
        issue(OP_DELETE, k, '0);
        issue(OP_LOOKUP, k, '0);
        issue(OP_DELETE, k, '0);
        idle(3);

        // Three keys in one empty bucket, deltas 0x41 and 0x1001 fold to zero
        do begin
            k = key_t'($urandom);
        end while (bucket_cnt[model_hash(k)] != 0);
        pool.push_back(k);
        pool.push_back(k ^ 32'h0000_0041);
        pool.push_back(k ^ 32'h0000_1001);
        issue(OP_INSERT, pool[8], value_t'($urandom));
        issue(OP_INSERT, pool[9], value_t'($urandom));
        issue(OP_INSERT, pool[10], value_t'($urandom));
        issue(OP_DELETE, pool[8], '0);
        issue(OP_INSERT, pool[10], value_t'($urandom));
        issue(OP_LOOKUP, pool[10], '0);
        idle(3);

        // Back-to-back bursts on the colliding keys
        repeat (4) begin
            repeat (40) issue(rand_op(), pick_key(8, 10), value_t'($urandom));
            idle(2);
        end

        // Long mixed run with idle gaps
        repeat (2000) begin
            issue(rand_op(), pick_key(0, pool.size() - 1), value_t'($urandom));
            idle($urandom_range(3, 0));
        end

        drain();
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: hw/htable_ingress.sv
module htable_ingress (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    init_done,
    input  logic                    req_valid,
    input  htable_pkg::htable_req_t req,
    output logic                    s1_valid,
    output htable_pkg::htable_req_t s1_req,
    output htable_pkg::hash_t       s1_hash
);
    import htable_pkg::*;

    logic accept;

    // Strobes are ignored until the table is cleared
    assign accept = req_valid & init_done;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= accept;
        end
    end

    // Hash is registered here so the way address comes straight from a flop
    always_ff @(posedge clk) begin
        if (accept) begin
            s1_req  <= req;
            s1_hash <= htable_hash(req.key);
        end
    end

endmodule

// File: hw/htable_pkg.sv
package htable_pkg;

    // ======================================================================
    // Widths and sizes
    // ======================================================================
    localparam int KEY_WID     = 32;
    localparam int VALUE_WID   = 16;
    localparam int HASH_WID    = 6;
    localparam int NUM_BUCKETS = 2**HASH_WID;
    localparam int NUM_WAYS    = 2;

    // Slices folded by the hash, last one zero-padded
    localparam int HASH_SLICES = (KEY_WID + HASH_WID - 1) / HASH_WID;

    typedef logic [KEY_WID-1:0]   key_t;
    typedef logic [VALUE_WID-1:0] value_t;
    typedef logic [HASH_WID-1:0]  hash_t;
    typedef logic                 way_idx_t;

    // ======================================================================
    // Operations and payloads
    // ======================================================================
    typedef enum logic [1:0] {
        OP_LOOKUP = 2'd0,
        OP_INSERT = 2'd1,
        OP_DELETE = 2'd2
    } htable_op_e;

    typedef struct packed {
        htable_op_e op;
        key_t       key;
        value_t     value;    // Insert only
    } htable_req_t;

    typedef struct packed {
        logic   valid;
        key_t   key;
        value_t value;
    } htable_entry_t;

    typedef struct packed {
        htable_op_e op;
        key_t       key;
        logic       found;    // Key present before the operation
        logic       full;     // Insert refused, no way available
        value_t     value;
    } htable_resp_t;

    // XOR fold of the key into a bucket index
    function automatic hash_t htable_hash(input key_t key);
        logic [HASH_SLICES*HASH_WID-1:0] padded;
        hash_t                           folded;
        padded              = '0;
        padded[KEY_WID-1:0] = key;
        folded              = '0;
        for (int i = 0; i < HASH_SLICES; i++) begin
            folded ^= padded[i*HASH_WID +: HASH_WID];
        end
        return folded;
    endfunction

endpackage

// File: hw/htable_resolve.sv
module htable_resolve (
    input  logic                                                 clk,
    input  logic                                                 arst_n,
    input  logic                                                 s1_valid,
    input  htable_pkg::htable_req_t                              s1_req,
    input  htable_pkg::hash_t                                    s1_hash,
    input  htable_pkg::htable_entry_t [htable_pkg::NUM_WAYS-1:0] way_entry,
    input  logic [htable_pkg::NUM_WAYS-1:0]                      way_hit,
    output logic [htable_pkg::NUM_WAYS-1:0]                      wr_en,
    output htable_pkg::hash_t                                    wr_hash,
    output htable_pkg::htable_entry_t                            wr_entry,
    output logic                                                 init_done,
    output logic                                                 resp_valid,
    output htable_pkg::htable_resp_t                             resp
);
    import htable_pkg::*;

    typedef enum logic {
        INIT_SWEEP,
        RUN
    } state_e;

    state_e      state;
    logic        sweep_go;
    hash_t       sweep_cnt;
    logic        s2_valid;
    htable_req_t s2_req;
    hash_t       s2_hash;
    logic        hit_any;
    logic        free_any;
    way_idx_t    hit_way;
    way_idx_t    free_way;
    logic        do_write;
    way_idx_t    wr_way;
    logic        full;

    // ======================================================================
    // Stage 2, aligned with the way read registers
    // ======================================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s2_valid   <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            s2_valid   <= s1_valid;
            resp_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        s2_req  <= s1_req;
        s2_hash <= s1_hash;
    end

    // ======================================================================
    // Clearing sweep after reset
    // ======================================================================
    // Sweep starts one cycle after release
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= INIT_SWEEP;
            sweep_go  <= 1'b0;
            sweep_cnt <= '0;
        end else begin
            sweep_go <= 1'b1;
            if (state == INIT_SWEEP && sweep_go) begin
                sweep_cnt <= sweep_cnt + 1'b1;
                if (sweep_cnt == hash_t'(NUM_BUCKETS - 1)) begin
                    state <= RUN;
                end
            end
        end
    end

    assign init_done = (state == RUN);

    // Lowest-numbered way wins for both hit and free
    always_comb begin
        hit_any  = 1'b0;
        free_any = 1'b0;
        hit_way  = '0;
        free_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (way_hit[w]) begin
                hit_any = 1'b1;
                hit_way = way_idx_t'(w);
            end
            if (!way_entry[w].valid) begin
                free_any = 1'b1;
                free_way = way_idx_t'(w);
            end
        end
    end

    // Write decision, shared port to all ways
    always_comb begin
        do_write = 1'b0;
        wr_way   = hit_way;
        full     = 1'b0;
        wr_hash  = s2_hash;
        wr_entry = '0;
        wr_en    = '0;
        if (state == INIT_SWEEP) begin
            wr_hash = sweep_cnt;
            wr_en   = {NUM_WAYS{sweep_go}};
        end else if (s2_valid) begin
            case (s2_req.op)
                OP_INSERT: begin
                    wr_entry.valid = 1'b1;
                    wr_entry.key   = s2_req.key;
                    wr_entry.value = s2_req.value;
                    if (hit_any) begin
                        do_write = 1'b1;
                    end else if (free_any) begin
                        do_write = 1'b1;
                        wr_way   = free_way;
                    end else begin
                        full = 1'b1;
                    end
                end
                // Invalid entry already on wr_entry
                OP_DELETE: do_write = hit_any;
                default:   do_write = 1'b0;
            endcase
            if (do_write) begin
                wr_en[wr_way] = 1'b1;
            end
        end
    end

    // Response register
    always_ff @(posedge clk) begin
        resp.op    <= s2_req.op;
        resp.key   <= s2_req.key;
        resp.found <= hit_any;
        resp.full  <= full;
        resp.value <= hit_any ? way_entry[hit_way].value : '0;
    end

endmodule

// File: hw/htable_top.sv
module htable_top (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     req_valid,
    input  htable_pkg::htable_req_t  req,
    output logic                     init_done,
    output logic                     resp_valid,
    output htable_pkg::htable_resp_t resp
);
    import htable_pkg::*;

    logic                               s1_valid;
    htable_req_t                        s1_req;
    hash_t                              s1_hash;
    htable_entry_t [NUM_WAYS-1:0]       way_entry;
    logic [NUM_WAYS-1:0]                way_hit;
    logic [NUM_WAYS-1:0]                wr_en;
    hash_t                              wr_hash;
    htable_entry_t                      wr_entry;

    htable_ingress u_ingress (
        .clk       (clk),
        .arst_n    (arst_n),
        .init_done (init_done),
        .req_valid (req_valid),
        .req       (req),
        .s1_valid  (s1_valid),
        .s1_req    (s1_req),
        .s1_hash   (s1_hash)
    );

    // One bank per way
    for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
        htable_way u_way (
            .clk      (clk),
            .arst_n   (arst_n),
            .s1_valid (s1_valid),
            .s1_key   (s1_req.key),
            .s1_hash  (s1_hash),
            .wr_en    (wr_en[g]),
            .wr_hash  (wr_hash),
            .wr_entry (wr_entry),
            .entry    (way_entry[g]),
            .hit      (way_hit[g])
        );
    end

    htable_resolve u_resolve (
        .clk        (clk),
        .arst_n     (arst_n),
        .s1_valid   (s1_valid),
        .s1_req     (s1_req),
        .s1_hash    (s1_hash),
        .way_entry  (way_entry),
        .way_hit    (way_hit),
        .wr_en      (wr_en),
        .wr_hash    (wr_hash),
        .wr_entry   (wr_entry),
        .init_done  (init_done),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

endmodule

// File: hw/htable_way.sv
module htable_way (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      s1_valid,
    input  htable_pkg::key_t          s1_key,
    input  htable_pkg::hash_t         s1_hash,
    input  logic                      wr_en,
    input  htable_pkg::hash_t         wr_hash,
    input  htable_pkg::htable_entry_t wr_entry,
    output htable_pkg::htable_entry_t entry,
    output logic                      hit
);
    import htable_pkg::*;

    htable_entry_t mem [NUM_BUCKETS];
    htable_entry_t rd_entry;
    logic          bypass;
    logic          match;

    // ======================================================================
    // Storage
    // ======================================================================
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_hash] <= wr_entry;
        end
    end

    // A write landing on the bucket being read wins over the array
    assign bypass   = wr_en && (wr_hash == s1_hash);
    assign rd_entry = bypass ? wr_entry : mem[s1_hash];

    // Key compare kept local to the bank
    assign match = rd_entry.valid && (rd_entry.key == s1_key);

    // ======================================================================
    // Read register
    // ======================================================================
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            entry <= rd_entry;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hit <= 1'b0;
        end else begin
            hit <= s1_valid & match;
        end
    end

endmodule

// File: src.f
hw/htable_pkg.sv
hw/htable_ingress.sv
hw/htable_way.sv
hw/htable_resolve.sv
hw/htable_top.sv
dv/htable_tb.sv
